// File: llc_addr_decode.sv
// ==============================
// set_busy must answer lookup_set in the same cycle
// out_valid is a one cycle pulse per issued item
// ==============================
`default_nettype none

module llc_addr_decode (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    input  llc_dec_pkg::dec_item_t in_item,
    output logic in_ready,
    input  logic set_busy,
    input  logic mem_ready,
    output llc_dec_pkg::llc_set_t lookup_set,
    output logic burst_pending,
    output logic dma_step,
    output logic burst_done,
    output logic out_valid,
    output llc_dec_pkg::dec_out_t out_item
);
    import llc_dec_pkg::*;

    line_addr_t burst_addr;
    line_addr_t line_addr;
    logic burst_last;
    logic is_dma;
    logic issue;
    dec_out_t next_out;
    logic out_valid_q;
    dec_out_t out_item_q;

    llc_dma_burst u_dma_burst (
        .clk(clk),
        .rst(rst),
        .step(dma_step),
        .item(in_item),
        .line_addr(burst_addr),
        .last(burst_last),
        .burst_pending(burst_pending),
        .burst_done(burst_done)
    );

    // line address per item kind
    always_comb begin
        case (in_item.kind)
            KIND_RST: line_addr = '0;
            KIND_DMA_NEXT: line_addr = burst_addr;
            default: line_addr = in_item.addr;
        endcase
    end

    assign is_dma = (in_item.kind == KIND_DMA_START) || (in_item.kind == KIND_DMA_NEXT);

    assign lookup_set = line_addr[LLC_SET_BITS-1:0];

    // pop only when the set is free and memory takes the item
    assign in_ready = !set_busy && mem_ready;
    assign issue = in_valid && in_ready;
    assign dma_step = issue && is_dma;

    assign next_out.kind = in_item.kind;
    assign next_out.tag = line_addr[LINE_ADDR_BITS-1 -: LLC_TAG_BITS];
    assign next_out.set = line_addr[LLC_SET_BITS-1:0];
    assign next_out.last = is_dma && burst_last;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out_valid_q <= 1'b0;
        end else begin
            out_valid_q <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            out_item_q <= next_out;
        end
    end

    assign out_valid = out_valid_q;
    assign out_item = out_item_q;

endmodule

`default_nettype wire

// File: llc_dec_pkg.sv
// ==============================
// widths, item kinds and structs for the llc input decoder
// the set index is the low part of the line address
// ==============================
`default_nettype none

package llc_dec_pkg;

    // address split
    localparam int LINE_ADDR_BITS = 16;
    localparam int LLC_SET_BITS = 6;
    localparam int LLC_TAG_BITS = 10;

    // line geometry and dma length
    localparam int WORDS_PER_LINE = 4;
    localparam int WORD_OFFSET_BITS = 2;
    localparam int DMA_LEN_BITS = 8;

    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;
    typedef logic [LLC_SET_BITS-1:0] llc_set_t;
    typedef logic [LLC_TAG_BITS-1:0] llc_tag_t;
    typedef logic [DMA_LEN_BITS-1:0] dma_len_t;
    typedef logic [WORD_OFFSET_BITS-1:0] word_offset_t;

    // what a pipeline entry stands for
    typedef enum logic [2:0] {
        KIND_RST,
        KIND_RSP,
        KIND_REQ,
        KIND_DMA_START,
        KIND_DMA_NEXT
    } item_kind_t;

    // dma read burst as presented on the input channel
    typedef struct packed {
        line_addr_t addr;
        word_offset_t word_offset;
        dma_len_t length;
    } dma_req_t;

    // entry of the arbiter to decode register
    // addr is don't care for the reset sweep and for continuations
    typedef struct packed {
        item_kind_t kind;
        line_addr_t addr;
        dma_req_t dma;
    } dec_item_t;

    // decoded item handed to the memory stage
    typedef struct packed {
        item_kind_t kind;
        llc_tag_t tag;
        llc_set_t set;
        logic last;
    } dec_out_t;

endpackage

`default_nettype wire

// File: llc_dma_burst.sv
// ==============================
// step only on the issue of a dma start or continuation
// ==============================
`default_nettype none

module llc_dma_burst (
    input  logic clk,
    input  logic rst,
    input  logic step,
    input  llc_dec_pkg::dec_item_t item,
    output llc_dec_pkg::line_addr_t line_addr,
    output logic last,
    output logic burst_pending,
    output logic burst_done
);
    import llc_dec_pkg::*;

    // one spare bit so the covered count can run past the length
    typedef logic [DMA_LEN_BITS:0] count_t;

    line_addr_t addr_q;
    count_t covered_q;
    dma_len_t length_q;
    logic pending_q;

    logic is_start;
    count_t covered_next;
    dma_len_t length_sel;

    assign is_start = (item.kind == KIND_DMA_START);

    always_comb begin
        if (is_start) begin
            // first line only covers from the word offset to the line end
            line_addr = item.dma.addr;
            covered_next = count_t'(WORDS_PER_LINE) - count_t'(item.dma.word_offset);
            length_sel = item.dma.length;
        end else begin
            line_addr = addr_q + line_addr_t'(1);
            covered_next = covered_q + count_t'(WORDS_PER_LINE);
            length_sel = length_q;
        end
    end

    assign last = (covered_next >= count_t'(length_sel));
    assign burst_done = step && last;
    assign burst_pending = pending_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pending_q <= 1'b0;
        end else if (step) begin
            pending_q <= !last;
        end
    end

    // burst position
    always_ff @(posedge clk) begin
        if (step) begin
            addr_q <= line_addr;
            covered_q <= covered_next;
            if (is_start) begin
                length_q <= item.dma.length;
            end
        end
    end

endmodule

`default_nettype wire

// File: llc_input_arbiter.sv
// ==============================
// sources hold valid and data until their get pulse
// one dma burst and one continuation of it in flight at most
// ==============================
`default_nettype none

module llc_input_arbiter (
    input  logic clk,
    input  logic rst,
    input  logic rst_tb_valid,
    input  logic rsp_valid,
    input  logic req_valid,
    input  logic dma_valid,
    input  llc_dec_pkg::line_addr_t rsp_addr,
    input  llc_dec_pkg::line_addr_t req_addr,
    input  llc_dec_pkg::dma_req_t dma_in,
    input  logic pipe_ready,
    input  logic burst_pending,
    input  logic dma_step,
    input  logic burst_done,
    output logic rst_get,
    output logic rsp_get,
    output logic req_get,
    output logic dma_get,
    output logic pipe_valid,
    output llc_dec_pkg::dec_item_t pipe_item
);
    import llc_dec_pkg::*;

    logic dma_busy;
    logic next_in_flight;
    logic sel_rst;
    logic sel_rsp;
    logic sel_req;
    logic sel_next;
    logic sel_dma;

    // fixed priority pick and entry build
    always_comb begin
        sel_rst = 1'b0;
        sel_rsp = 1'b0;
        sel_req = 1'b0;
        sel_next = 1'b0;
        sel_dma = 1'b0;
        pipe_item.kind = KIND_RST;
        pipe_item.addr = '0;
        pipe_item.dma = dma_in;
        if (rst_tb_valid && !dma_busy) begin
            sel_rst = 1'b1;
        end else if (rsp_valid) begin
            sel_rsp = 1'b1;
            pipe_item.kind = KIND_RSP;
            pipe_item.addr = rsp_addr;
        end else if (req_valid) begin
            sel_req = 1'b1;
            pipe_item.kind = KIND_REQ;
            pipe_item.addr = req_addr;
        end else if (burst_pending && !next_in_flight) begin
            // continuation address comes from the burst tracker
            sel_next = 1'b1;
            pipe_item.kind = KIND_DMA_NEXT;
        end else if (dma_valid && !dma_busy) begin
            sel_dma = 1'b1;
            pipe_item.kind = KIND_DMA_START;
            pipe_item.addr = dma_in.addr;
        end
    end

    assign pipe_valid = sel_rst | sel_rsp | sel_req | sel_next | sel_dma;

    // gets only in an accepting cycle
    assign rst_get = sel_rst & pipe_ready;
    assign rsp_get = sel_rsp & pipe_ready;
    assign req_get = sel_req & pipe_ready;
    assign dma_get = sel_dma & pipe_ready;

    // burst ownership, held from dma_get until the last line issues
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            dma_busy <= 1'b0;
        end else if (burst_done) begin
            dma_busy <= 1'b0;
        end else if (dma_get) begin
            dma_busy <= 1'b1;
        end
    end

    // continuation sitting in the pipe register, not issued yet
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            next_in_flight <= 1'b0;
        end else if (dma_step) begin
            next_in_flight <= 1'b0;
        end else if (sel_next && pipe_ready) begin
            next_in_flight <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: llc_input_decoder.sv
// ==============================
// two cycles from a get to out_valid without back-pressure
// channels hold valid and data until their get pulse
// ==============================
`default_nettype none

module llc_input_decoder (
    input  logic clk,
    input  logic rst,
    input  logic rst_tb_valid,
    input  logic rsp_valid,
    input  logic req_valid,
    input  logic dma_valid,
    input  llc_dec_pkg::line_addr_t rsp_addr,
    input  llc_dec_pkg::line_addr_t req_addr,
    input  llc_dec_pkg::dma_req_t dma_in,
    input  logic set_busy,
    input  logic mem_ready,
    output logic rst_get,
    output logic rsp_get,
    output logic req_get,
    output logic dma_get,
    output llc_dec_pkg::llc_set_t lookup_set,
    output logic out_valid,
    output llc_dec_pkg::dec_out_t out_item
);
    import llc_dec_pkg::*;

    // arbiter to pipe register
    logic arb_valid;
    logic arb_ready;
    dec_item_t arb_item;

    // pipe register to decode stage
    logic dec_valid;
    logic dec_ready;
    dec_item_t dec_item;

    // burst tracker feedback
    logic burst_pending;
    logic dma_step;
    logic burst_done;

    llc_input_arbiter u_arbiter (
        .clk(clk),
        .rst(rst),
        .rst_tb_valid(rst_tb_valid),
        .rsp_valid(rsp_valid),
        .req_valid(req_valid),
        .dma_valid(dma_valid),
        .rsp_addr(rsp_addr),
        .req_addr(req_addr),
        .dma_in(dma_in),
        .pipe_ready(arb_ready),
        .burst_pending(burst_pending),
        .dma_step(dma_step),
        .burst_done(burst_done),
        .rst_get(rst_get),
        .rsp_get(rsp_get),
        .req_get(req_get),
        .dma_get(dma_get),
        .pipe_valid(arb_valid),
        .pipe_item(arb_item)
    );

    llc_pipe_reg u_pipe_reg (
        .clk(clk),
        .rst(rst),
        .in_valid(arb_valid),
        .in_ready(arb_ready),
        .in_item(arb_item),
        .out_valid(dec_valid),
        .out_ready(dec_ready),
        .out_item(dec_item)
    );

    llc_addr_decode u_addr_decode (
        .clk(clk),
        .rst(rst),
        .in_valid(dec_valid),
        .in_item(dec_item),
        .in_ready(dec_ready),
        .set_busy(set_busy),
        .mem_ready(mem_ready),
        .lookup_set(lookup_set),
        .burst_pending(burst_pending),
        .dma_step(dma_step),
        .burst_done(burst_done),
        .out_valid(out_valid),
        .out_item(out_item)
    );

endmodule

`default_nettype wire

// File: llc_pipe_reg.sv
// ==============================
// single entry, refills in the cycle it is popped
// ==============================
`default_nettype none

module llc_pipe_reg (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    output logic in_ready,
    input  llc_dec_pkg::dec_item_t in_item,
    output logic out_valid,
    input  logic out_ready,
    output llc_dec_pkg::dec_item_t out_item
);
    import llc_dec_pkg::*;

    logic full;
    dec_item_t item_q;

    // room when empty or draining this cycle
    assign in_ready = !full || out_ready;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            full <= 1'b0;
        end else if (in_ready) begin
            full <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            item_q <= in_item;
        end
    end

    assign out_valid = full;
    assign out_item = item_q;

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# compile with Verilator and run; pass only if the pass message shows up
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_llc_input_decoder -f tb.f

out=$(./obj_dir/Vtb_llc_input_decoder 2>&1) || true
echo "$out"
echo "$out" | grep -q "TESTBENCH PASSED"

// File: tb.f
llc_dec_pkg.sv
llc_dma_burst.sv
llc_addr_decode.sv
llc_pipe_reg.sv
llc_input_arbiter.sv
llc_input_decoder.sv
tb_llc_input_decoder.sv

// File: tb_llc_input_decoder.sv
// ==============================
// random traffic from an xorshift generator, seed 1
// set_busy answers lookup_set combinationally, as the memory side would
// ==============================
`default_nettype none

module tb_llc_input_decoder;
    import llc_dec_pkg::*;

    // items accepted before the sources go quiet
    localparam int N_ITEMS = 300;
    // up to 6 lines per item, doubled for stalls, plus reset and drain
    localparam int MAX_CYCLES = N_ITEMS * 12 + 400;

    logic clk;
    logic rst;
    logic rst_tb_valid;
    logic rsp_valid;
    logic req_valid;
    logic dma_valid;
    line_addr_t rsp_addr;
    line_addr_t req_addr;
    dma_req_t dma_in;
    logic set_busy;
    logic mem_ready;
    logic rst_get;
    logic rsp_get;
    logic req_get;
    logic dma_get;
    llc_set_t lookup_set;
    logic out_valid;
    dec_out_t out_item;

    llc_set_t busy_set;
    logic [31:0] rng_state = 32'd1;
    logic any_valid = 1'b0;

    // model state, written by the monitor at the falling edge
    dec_out_t exp_plain[$];
    dec_out_t exp_dma[$];
    int cycles = 0;
    int accepted = 0;
    logic stall_prev = 1'b0;
    llc_set_t prev_lookup = '0;
    logic rst_taken = 1'b0;
    logic rsp_taken = 1'b0;
    logic req_taken = 1'b0;
    logic dma_taken = 1'b0;
    logic drained = 1'b0;

    llc_input_decoder u_dut (
        .clk(clk),
        .rst(rst),
        .rst_tb_valid(rst_tb_valid),
        .rsp_valid(rsp_valid),
        .req_valid(req_valid),
        .dma_valid(dma_valid),
        .rsp_addr(rsp_addr),
        .req_addr(req_addr),
        .dma_in(dma_in),
        .set_busy(set_busy),
        .mem_ready(mem_ready),
        .rst_get(rst_get),
        .rsp_get(rsp_get),
        .req_get(req_get),
        .dma_get(dma_get),
        .lookup_set(lookup_set),
        .out_valid(out_valid),
        .out_item(out_item)
    );

    // set table answer for the held item
    assign set_busy = (lookup_set == busy_set);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand_next();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // half of the addresses land near the busy sets
    function automatic line_addr_t rand_addr();
        logic [31:0] r;
        r = rand_next();
        if (r[31]) begin
            return {r[15:6], 3'b000, r[2:0]};
        end else begin
            return r[15:0];
        end
    endfunction

    // tag is the high part of the line address, set the low part
    function automatic dec_out_t plain_line(input item_kind_t kind, input line_addr_t addr);
        dec_out_t o;
        o.kind = kind;
        o.tag = llc_tag_t'(addr >> LLC_SET_BITS);
        o.set = llc_set_t'(addr % (1 << LLC_SET_BITS));
        o.last = 1'b0;
        return o;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            stop_with_failure($sformatf("** Error: %s expected %0h actual %0h",
                                        name, expected, actual));
        end
    endtask

    // one line per started group of words
    task automatic expand_dma(input dma_req_t req);
        int total;
        int lines;
        dec_out_t o;
        total = int'(req.word_offset) + int'(req.length);
        lines = (total + WORDS_PER_LINE - 1) / WORDS_PER_LINE;
        for (int i = 0; i < lines; i++) begin
            o = plain_line(i == 0 ? KIND_DMA_START : KIND_DMA_NEXT,
                           req.addr + line_addr_t'(i));
            o.last = (i == lines - 1);
            exp_dma.push_back(o);
        end
    endtask

    // valid and data held until the get seen in the last cycle
    task automatic drive_inputs();
        logic [31:0] r;
        logic [31:0] r2;
        logic gen_on;
        logic raised;
        dma_req_t d;
        r = rand_next();
        r2 = rand_next();
        gen_on = (accepted < N_ITEMS);
        raised = 1'b0;
        mem_ready <= (r[1:0] != 2'b00);
        // move the busy set now and then
        if (r[4:2] == 3'b000) begin
            busy_set <= llc_set_t'(r[7:5]);
        end
        if (!rst_tb_valid || rst_taken) begin
            rst_tb_valid <= gen_on && (r[11:8] == 4'd0);
            raised = raised || (gen_on && (r[11:8] == 4'd0));
        end
        if (!rsp_valid || rsp_taken) begin
            rsp_valid <= gen_on && (r[14:12] < 3'd3);
            rsp_addr <= rand_addr();
            raised = raised || (gen_on && (r[14:12] < 3'd3));
        end
        if (!req_valid || req_taken) begin
            req_valid <= gen_on && (r[17:15] < 3'd3);
            req_addr <= rand_addr();
            raised = raised || (gen_on && (r[17:15] < 3'd3));
        end
        if (!dma_valid || dma_taken) begin
            d.addr = rand_addr();
            d.word_offset = r2[1:0];
            d.length = 8'd1 + r2[15:8] % 8'd20;
            dma_valid <= gen_on && (r[20:18] == 3'd0);
            dma_in <= d;
            raised = raised || (gen_on && (r[20:18] == 3'd0));
        end
        any_valid <= any_valid || raised;
    endtask

    // checks and model updates where all outputs are settled
    always @(negedge clk) begin : monitor
        dec_out_t expected;
        int gets;
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            stop_with_failure($sformatf("timeout after %0d cycles with %0d items accepted",
                                        MAX_CYCLES, accepted));
        end else begin
            gets = $countones({rst_get, rsp_get, req_get, dma_get});
            if (stall_prev) begin
                check_value("out_valid after a stalled cycle", 32'd0, 32'(out_valid));
            end
            stall_prev = set_busy || !mem_ready;
            if (!any_valid) begin
                check_value("gets before any valid", 32'd0, 32'(gets));
                check_value("out_valid before any valid", 32'd0, 32'(out_valid));
            end
            check_value("more than one get", 32'd0, 32'(gets > 1));

            // outputs first, so a burst ending here frees the next dma_get
            if (out_valid) begin
                if (out_item.kind == KIND_DMA_START || out_item.kind == KIND_DMA_NEXT) begin
                    if (exp_dma.size() == 0) begin
                        stop_with_failure("a dma line came out with no burst outstanding");
                    end else begin
                        expected = exp_dma.pop_front();
                        check_value("dma line", 32'(expected), 32'(out_item));
                        check_value("lookup_set of dma line", 32'(expected.set),
                                    32'(prev_lookup));
                    end
                end else if (exp_plain.size() == 0) begin
                    stop_with_failure("an item came out that no source had handed over");
                end else begin
                    expected = exp_plain.pop_front();
                    check_value("non-dma item", 32'(expected), 32'(out_item));
                    check_value("lookup_set of non-dma item", 32'(expected.set),
                                32'(prev_lookup));
                end
            end

            // fixed priority
            if (rst_tb_valid && rsp_valid && exp_dma.size() == 0) begin
                check_value("rsp_get over reset sweep", 32'd0, 32'(rsp_get));
            end
            if (rsp_valid) begin
                check_value("req_get over response", 32'd0, 32'(req_get));
            end

            if (rst_get) begin
                exp_plain.push_back(plain_line(KIND_RST, '0));
            end
            if (rsp_get) begin
                exp_plain.push_back(plain_line(KIND_RSP, rsp_addr));
            end
            if (req_get) begin
                exp_plain.push_back(plain_line(KIND_REQ, req_addr));
            end
            if (dma_get) begin
                if (exp_dma.size() != 0) begin
                    stop_with_failure("dma_get fired before the previous burst was output");
                end else begin
                    expand_dma(dma_in);
                end
            end

            rst_taken = rst_get;
            rsp_taken = rsp_get;
            req_taken = req_get;
            dma_taken = dma_get;
            prev_lookup = lookup_set;
            accepted = accepted + gets;
            drained = (accepted >= N_ITEMS) && !rst_tb_valid && !rsp_valid
                && !req_valid && !dma_valid && exp_plain.size() == 0 && exp_dma.size() == 0;
        end
    end

    initial begin
        rst = 1'b0;
        rst_tb_valid = 1'b0;
        rsp_valid = 1'b0;
        req_valid = 1'b0;
        dma_valid = 1'b0;
        rsp_addr = '0;
        req_addr = '0;
        dma_in = '0;
        mem_ready = 1'b1;
        busy_set = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b1;
        // idle cycles to watch the outputs stay low
        repeat (3) @(posedge clk);
        while (!drained) begin
            @(posedge clk);
            drive_inputs();
        end
        // nothing more may come out once the model is empty
        repeat (8) @(posedge clk);
        if (exp_plain.size() == 0 && exp_dma.size() == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            stop_with_failure("expected items were never output");
        end
    end

endmodule

`default_nettype wire
